// ==== src/rv_pkg.sv ====
/*
  Shared types and constants for the RV32I single-cycle core.
  Modules refer to these by scoped names such as rv_pkg::word_t.
*/
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [xlen-1:0] addr_t;
  typedef logic [4:0]      reg_addr_t;

  localparam addr_t INITIAL_PC = 32'h0000_0000;

  // Major opcodes ------------------
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;

  // Control encodings ------------------
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_func_e;

  typedef enum logic {opa_rs1, opa_pc} operand_a_sel_e;
  typedef enum logic {opb_rs2, opb_imm} operand_b_sel_e;

  typedef enum logic [1:0] {wb_alu, wb_memory, wb_pc_plus_4, wb_immediate} writeback_sel_e;

  // alu_target drops bit 0 of the ALU result
  typedef enum logic [1:0] {npc_pc_plus_4, npc_pc_plus_imm, npc_alu_target} next_pc_sel_e;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_format_e;

  // Bundles between blocks ------------------
  typedef struct packed {
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
  } decode_t;

  typedef struct packed {
    alu_func_e      alu_func;
    operand_a_sel_e operand_a_sel;
    operand_b_sel_e operand_b_sel;
    writeback_sel_e writeback_sel;
    next_pc_sel_e   next_pc_sel;
    imm_format_e    imm_format;
    logic           regfile_write_enable;
    logic           data_write_enable;
  } ctrl_t;

  typedef struct packed {
    logic equal;
    logic less_signed;
    logic less_unsigned;
  } alu_flags_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  write_enable;
  } dmem_req_t;

endpackage

// ==== src/alu.sv ====
/*
  Combinational ALU for the RV32I integer operations.
  Flags always compare the two operands, so branches reuse them.
*/
`timescale 1ns/1ps

module alu (
  input  rv_pkg::alu_func_e  alu_func,
  input  rv_pkg::word_t      operand_a,
  input  rv_pkg::word_t      operand_b,
  output rv_pkg::word_t      result,
  output rv_pkg::alu_flags_t flags
);

  logic [4:0] shamt;

  // Only the low five bits count for shifts
  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_func)
      rv_pkg::alu_add:    result = operand_a + operand_b;
      rv_pkg::alu_sub:    result = operand_a - operand_b;
      rv_pkg::alu_sll:    result = operand_a << shamt;
      rv_pkg::alu_slt:    result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      rv_pkg::alu_sltu:   result = {31'b0, operand_a < operand_b};
      rv_pkg::alu_xor:    result = operand_a ^ operand_b;
      rv_pkg::alu_srl:    result = operand_a >> shamt;
      rv_pkg::alu_sra:    result = rv_pkg::word_t'($signed(operand_a) >>> shamt);
      rv_pkg::alu_or:     result = operand_a | operand_b;
      rv_pkg::alu_and:    result = operand_a & operand_b;
      rv_pkg::alu_pass_b: result = operand_b;
      default:            result = '0;
    endcase
  end

  // ------------------------------
  // Compare flags for branches
  // ------------------------------
  always_comb begin
    flags.equal         = (operand_a == operand_b);
    flags.less_signed   = ($signed(operand_a) < $signed(operand_b));
    flags.less_unsigned = (operand_a < operand_b);
  end

endmodule

// ==== src/immediate_generator.sv ====
/*
  Builds the sign-extended immediate for the selected format.
*/
`timescale 1ns/1ps

module immediate_generator (
  input  rv_pkg::word_t       inst,
  input  rv_pkg::imm_format_e imm_format,
  output rv_pkg::word_t       immediate
);

  always_comb begin
    case (imm_format)
      rv_pkg::imm_i: immediate = {{20{inst[31]}}, inst[31:20]};
      rv_pkg::imm_s: immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      // Branch offsets are in halfwords
      rv_pkg::imm_b: begin
        immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      rv_pkg::imm_u: immediate = {inst[31:12], 12'b0};
      rv_pkg::imm_j: begin
        immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default:       immediate = '0;
    endcase
  end

endmodule

// ==== src/regfile.sv ====
/*
  Integer register file, two asynchronous reads and one write port.
  x0 reads as zero and ignores writes.
*/
`timescale 1ns/1ps

module regfile (
  input  logic              clock,
  input  logic              rst_n,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::reg_addr_t rd_addr,
  input  rv_pkg::word_t     rd_data,
  input  logic              write_enable,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  rv_pkg::word_t regs [32];

  // No writes while the core is held in reset
  always_ff @(posedge clock) begin
    if (rst_n && write_enable && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== src/control_unit.sv ====
/*
  Main decoder. Turns opcode and function fields into data path controls
  and resolves conditional branches from the compare flags.
*/
`timescale 1ns/1ps

module control_unit (
  input  logic               rst_n,
  input  rv_pkg::decode_t    decode,
  input  rv_pkg::alu_flags_t flags,
  output rv_pkg::ctrl_t      ctrl
);

  rv_pkg::alu_func_e arith_func;
  logic              branch_taken;

  // ------------------------------
  // ALU function for op and op_imm
  // ------------------------------
  always_comb begin
    case (decode.funct3)
      3'b000: begin
        // sub only exists in register form
        if ((decode.opcode == rv_pkg::opcode_op) && decode.funct7[5]) begin
          arith_func = rv_pkg::alu_sub;
        end else begin
          arith_func = rv_pkg::alu_add;
        end
      end
      3'b001:  arith_func = rv_pkg::alu_sll;
      3'b010:  arith_func = rv_pkg::alu_slt;
      3'b011:  arith_func = rv_pkg::alu_sltu;
      3'b100:  arith_func = rv_pkg::alu_xor;
      3'b101:  arith_func = decode.funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  arith_func = rv_pkg::alu_or;
      default: arith_func = rv_pkg::alu_and;
    endcase
  end

  always_comb begin
    case (decode.funct3)
      3'b000:  branch_taken = flags.equal;
      3'b001:  branch_taken = !flags.equal;
      3'b100:  branch_taken = flags.less_signed;
      3'b101:  branch_taken = !flags.less_signed;
      3'b110:  branch_taken = flags.less_unsigned;
      3'b111:  branch_taken = !flags.less_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

  // ------------------------------
  // Per-opcode controls
  // ------------------------------
  always_comb begin
    // Unknown opcodes fall through as a nop
    ctrl.alu_func             = rv_pkg::alu_add;
    ctrl.operand_a_sel        = rv_pkg::opa_rs1;
    ctrl.operand_b_sel        = rv_pkg::opb_imm;
    ctrl.writeback_sel        = rv_pkg::wb_alu;
    ctrl.next_pc_sel          = rv_pkg::npc_pc_plus_4;
    ctrl.imm_format           = rv_pkg::imm_i;
    ctrl.regfile_write_enable = 1'b0;
    ctrl.data_write_enable    = 1'b0;

    case (decode.opcode)
      rv_pkg::opcode_op: begin
        ctrl.alu_func             = arith_func;
        ctrl.operand_b_sel        = rv_pkg::opb_rs2;
        ctrl.regfile_write_enable = 1'b1;
      end
      rv_pkg::opcode_op_imm: begin
        ctrl.alu_func             = arith_func;
        ctrl.regfile_write_enable = 1'b1;
      end
      rv_pkg::opcode_load: begin
        ctrl.writeback_sel        = rv_pkg::wb_memory;
        ctrl.regfile_write_enable = 1'b1;
      end
      rv_pkg::opcode_store: begin
        ctrl.imm_format        = rv_pkg::imm_s;
        ctrl.data_write_enable = 1'b1;
      end
      rv_pkg::opcode_branch: begin
        ctrl.operand_b_sel = rv_pkg::opb_rs2;
        ctrl.imm_format    = rv_pkg::imm_b;
        ctrl.next_pc_sel   = branch_taken ? rv_pkg::npc_pc_plus_imm : rv_pkg::npc_pc_plus_4;
      end
      rv_pkg::opcode_jal: begin
        ctrl.imm_format           = rv_pkg::imm_j;
        ctrl.writeback_sel        = rv_pkg::wb_pc_plus_4;
        ctrl.next_pc_sel          = rv_pkg::npc_pc_plus_imm;
        ctrl.regfile_write_enable = 1'b1;
      end
      rv_pkg::opcode_jalr: begin
        ctrl.writeback_sel        = rv_pkg::wb_pc_plus_4;
        ctrl.next_pc_sel          = rv_pkg::npc_alu_target;
        ctrl.regfile_write_enable = 1'b1;
      end
      rv_pkg::opcode_lui: begin
        ctrl.alu_func             = rv_pkg::alu_pass_b;
        ctrl.imm_format           = rv_pkg::imm_u;
        ctrl.writeback_sel        = rv_pkg::wb_immediate;
        ctrl.regfile_write_enable = 1'b1;
      end
      rv_pkg::opcode_auipc: begin
        ctrl.operand_a_sel        = rv_pkg::opa_pc;
        ctrl.imm_format           = rv_pkg::imm_u;
        ctrl.regfile_write_enable = 1'b1;
      end
      default: ;
    endcase

    // Nothing is written while reset is held
    if (!rst_n) begin
      ctrl.regfile_write_enable = 1'b0;
      ctrl.data_write_enable    = 1'b0;
    end
  end

endmodule

// ==== src/singlecycle_datapath.sv ====
/*
  Single-cycle data path: field extraction, PC register, operand and
  write-back muxes, and next-PC selection around the ALU and register file.
*/
`timescale 1ns/1ps

module singlecycle_datapath (
  input  logic               clock,
  input  logic               rst_n,
  input  rv_pkg::word_t      inst,
  input  rv_pkg::ctrl_t      ctrl,
  input  rv_pkg::word_t      data_rdata,
  output rv_pkg::decode_t    decode,
  output rv_pkg::alu_flags_t flags,
  output rv_pkg::addr_t      pc,
  output rv_pkg::dmem_req_t  dmem_req
);

  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::reg_addr_t rd_addr;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     immediate;
  rv_pkg::word_t     operand_a;
  rv_pkg::word_t     operand_b;
  rv_pkg::word_t     alu_result;
  rv_pkg::word_t     rd_data;
  rv_pkg::addr_t     pc_plus_4;
  rv_pkg::addr_t     pc_plus_imm;
  rv_pkg::addr_t     next_pc;

  // Instruction fields ------------------
  assign rs1_addr      = inst[19:15];
  assign rs2_addr      = inst[24:20];
  assign rd_addr       = inst[11:7];
  assign decode.opcode = inst[6:0];
  assign decode.funct3 = inst[14:12];
  assign decode.funct7 = inst[31:25];

  regfile regs (
    .clock        (clock),
    .rst_n        (rst_n),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .write_enable (ctrl.regfile_write_enable),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  immediate_generator igen (
    .inst       (inst),
    .imm_format (ctrl.imm_format),
    .immediate  (immediate)
  );

  assign operand_a = (ctrl.operand_a_sel == rv_pkg::opa_pc) ? pc : rs1_data;
  assign operand_b = (ctrl.operand_b_sel == rv_pkg::opb_imm) ? immediate : rs2_data;

  alu alu_core (
    .alu_func  (ctrl.alu_func),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (alu_result),
    .flags     (flags)
  );

  // ------------------------------
  // Write-back and next PC
  // ------------------------------
  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + immediate;

  always_comb begin
    case (ctrl.writeback_sel)
      rv_pkg::wb_memory:    rd_data = data_rdata;
      rv_pkg::wb_pc_plus_4: rd_data = pc_plus_4;
      rv_pkg::wb_immediate: rd_data = immediate;
      default:              rd_data = alu_result;
    endcase
  end

  always_comb begin
    case (ctrl.next_pc_sel)
      rv_pkg::npc_pc_plus_imm: next_pc = pc_plus_imm;
      rv_pkg::npc_alu_target:  next_pc = {alu_result[31:1], 1'b0};
      default:                 next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= rv_pkg::INITIAL_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // Data memory request, word address from the ALU
  assign dmem_req.addr         = alu_result;
  assign dmem_req.wdata        = rs2_data;
  assign dmem_req.write_enable = ctrl.data_write_enable;

endmodule

// ==== src/rv_core.sv ====
/*
  RV32I single-cycle core top level. Instruction and data memories sit
  outside and answer combinationally; data writes commit on the clock edge.
*/
`timescale 1ns/1ps

module rv_core (
  input  logic              clock,
  input  logic              rst_n,
  output rv_pkg::addr_t     inst_addr,
  input  rv_pkg::word_t     inst,
  output rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::word_t     data_rdata
);

  rv_pkg::decode_t    decode;
  rv_pkg::alu_flags_t flags;
  rv_pkg::ctrl_t      ctrl;

  control_unit ctrl_unit (
    .rst_n  (rst_n),
    .decode (decode),
    .flags  (flags),
    .ctrl   (ctrl)
  );

  // PC drives the instruction port directly
  singlecycle_datapath datapath (
    .clock      (clock),
    .rst_n      (rst_n),
    .inst       (inst),
    .ctrl       (ctrl),
    .data_rdata (data_rdata),
    .decode     (decode),
    .flags      (flags),
    .pc         (inst_addr),
    .dmem_req   (dmem_req)
  );

endmodule

// ==== verif/tb_rv_programs.svh ====
/*
  Encoded RV32I test programs. Each program task writes the ROM from
  address 0 and ends in a jal-to-self halt loop. Included inside the
  testbench module, which owns rom, prog_len and halt_pc.
*/

// Operation tables as {funct7[5], funct3}
localparam logic [3:0] r_ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3,
                                      4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
localparam logic [3:0] i_ops [9] = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h6,
                                     4'h7, 4'h1, 4'h5, 4'hd};
localparam logic [11:0] ls_imm [4] = '{12'h7ff, 12'h800, 12'h001, 12'hfff};

// Six branches, each once taken and once not
localparam logic [2:0] br_f3 [12] = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4,
                                      3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
localparam logic [4:0] br_rs1 [12] = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2,
                                       5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
localparam logic [4:0] br_rs2 [12] = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd2, 5'd1,
                                       5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};

// Store areas in data RAM
localparam logic [11:0] arith_base   = 12'h200;
localparam logic [11:0] marker_base  = 12'h280;
localparam logic [11:0] copy_base    = 12'h300;
localparam logic [11:0] jump_base    = 12'h380;
localparam logic [11:0] taken_marker = 12'h100;
localparam logic [11:0] fall_marker  = 12'h200;

// Jump program constants, addresses follow its layout
localparam logic [19:0] lui_imm    = 20'habcde;
localparam logic [19:0] auipc_imm  = 20'h80010;
localparam int          auipc_pc   = 4;
localparam int          jal_pc     = 16;
localparam int          jal_offset = 12;
localparam int          jalr_pc    = 36;
localparam int          jalr_base  = 47;
localparam int          jalr_imm   = 2;

// ------------------------------
// Instruction encoders
// ------------------------------
function automatic rv_pkg::word_t r_type(input logic [3:0] op,
                                         input rv_pkg::reg_addr_t rd, rs1, rs2);
  return {1'b0, op[3], 5'b0, rs2, rs1, op[2:0], rd, rv_pkg::opcode_op};
endfunction

function automatic rv_pkg::word_t i_type(input logic [6:0] opcode, input logic [2:0] f3,
                                         input rv_pkg::reg_addr_t rd, rs1,
                                         input logic [11:0] imm);
  return {imm, rs1, f3, rd, opcode};
endfunction

function automatic rv_pkg::word_t s_type(input rv_pkg::reg_addr_t rs2, rs1,
                                         input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::opcode_store};
endfunction

function automatic rv_pkg::word_t b_type(input logic [2:0] f3,
                                         input rv_pkg::reg_addr_t rs1, rs2,
                                         input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::opcode_branch};
endfunction

function automatic rv_pkg::word_t u_type(input logic [6:0] opcode,
                                         input rv_pkg::reg_addr_t rd,
                                         input logic [19:0] imm);
  return {imm, rd, opcode};
endfunction

function automatic rv_pkg::word_t j_type(input rv_pkg::reg_addr_t rd,
                                         input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::opcode_jal};
endfunction

// Shifts carry shamt and funct7 in the immediate field
function automatic logic [11:0] imm_field(input logic [3:0] op, input logic [11:0] imm,
                                          input logic [4:0] shamt);
  if (op[1:0] == 2'b01) begin
    return {1'b0, op[3], 5'b0, shamt};
  end
  return imm;
endfunction

// x1 negative, x2 and x3 small positives
function automatic rv_pkg::word_t branch_operand(input rv_pkg::reg_addr_t r);
  return (r == 5'd1) ? 32'hffff_ffff : 32'd1;
endfunction

// ------------------------------
// ROM writers
// ------------------------------
task automatic clear_rom();
  for (int i = 0; i < 256; i++) begin
    rom[8'(i)] = nop;
  end
  prog_len = 0;
endtask

task automatic put(input rv_pkg::word_t instruction);
  rom[8'(prog_len)] = instruction;
  prog_len++;
endtask

task automatic put_halt();
  halt_pc = rv_pkg::addr_t'(prog_len) << 2;
  put(j_type(5'd0, 21'd0));
endtask

// lui plus addi, upper part rounded for the signed low half
task automatic put_li(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t value);
  rv_pkg::word_t upper;
  upper = value + 32'h800;
  put(u_type(rv_pkg::opcode_lui, rd, upper[31:12]));
  put(i_type(rv_pkg::opcode_op_imm, 3'b000, rd, rd, value[11:0]));
endtask

// ------------------------------
// Programs
// ------------------------------
task automatic arith_program(input rv_pkg::word_t a, b, input logic [11:0] imm,
                             input logic [4:0] shamt);
  clear_rom();
  put_li(5'd1, a);
  put_li(5'd2, b);
  for (int k = 0; k < 10; k++) begin
    put(r_type(r_ops[k], 5'd3, 5'd1, 5'd2));
    put(s_type(5'd3, 5'd0, arith_base + 12'(4 * k)));
  end
  for (int k = 0; k < 9; k++) begin
    put(i_type(rv_pkg::opcode_op_imm, i_ops[k][2:0], 5'd3, 5'd1,
               imm_field(i_ops[k], imm, shamt)));
    put(s_type(5'd3, 5'd0, arith_base + 12'(4 * (10 + k))));
  end
  // Write to x0, then store x0
  put(i_type(rv_pkg::opcode_op_imm, 3'b000, 5'd0, 5'd1, 12'h005));
  put(s_type(5'd0, 5'd0, arith_base + 12'(4 * 19)));
  put_halt();
endtask

task automatic copy_program();
  clear_rom();
  for (int k = 0; k < 4; k++) begin
    put(i_type(rv_pkg::opcode_load, 3'b010, 5'd5, 5'd0, 12'(4 * k)));
    put(i_type(rv_pkg::opcode_op_imm, 3'b000, 5'd5, 5'd5, ls_imm[k]));
    put(s_type(5'd5, 5'd0, copy_base + 12'(4 * k)));
  end
  put_halt();
endtask

task automatic branch_program();
  rv_pkg::word_t value;
  clear_rom();
  for (int r = 1; r < 4; r++) begin
    value = branch_operand(5'(r));
    put(i_type(rv_pkg::opcode_op_imm, 3'b000, 5'(r), 5'd0, value[11:0]));
  end
  // Fall-through path, then jal over the taken path
  for (int c = 0; c < 12; c++) begin
    put(b_type(br_f3[c], br_rs1[c], br_rs2[c], 13'd16));
    put(i_type(rv_pkg::opcode_op_imm, 3'b000, 5'd4, 5'd0, fall_marker + 12'(c)));
    put(s_type(5'd4, 5'd0, marker_base + 12'(4 * c)));
    put(j_type(5'd0, 21'd12));
    put(i_type(rv_pkg::opcode_op_imm, 3'b000, 5'd4, 5'd0, taken_marker + 12'(c)));
    put(s_type(5'd4, 5'd0, marker_base + 12'(4 * c)));
  end
  put_halt();
endtask

task automatic jump_program();
  clear_rom();
  put(u_type(rv_pkg::opcode_lui, 5'd7, lui_imm));
  put(u_type(rv_pkg::opcode_auipc, 5'd6, auipc_imm));
  put(s_type(5'd7, 5'd0, jump_base));
  put(s_type(5'd6, 5'd0, jump_base + 12'd4));
  put(j_type(5'd1, 21'(jal_offset)));
  // Skipped by jal
  put(i_type(rv_pkg::opcode_op_imm, 3'b000, 5'd9, 5'd0, 12'h666));
  put(s_type(5'd9, 5'd0, jump_base + 12'h20));
  put(s_type(5'd1, 5'd0, jump_base + 12'd8));
  put(i_type(rv_pkg::opcode_op_imm, 3'b000, 5'd10, 5'd0, 12'(jalr_base)));
  put(i_type(rv_pkg::opcode_jalr, 3'b000, 5'd11, 5'd10, 12'(jalr_imm)));
  // Skipped by jalr
  put(i_type(rv_pkg::opcode_op_imm, 3'b000, 5'd9, 5'd0, 12'h667));
  put(s_type(5'd9, 5'd0, jump_base + 12'h24));
  put(s_type(5'd11, 5'd0, jump_base + 12'd12));
  put_halt();
endtask

// ==== verif/tb_rv_core.sv ====
/*
  Directed testbench for the single-cycle RV32I core. Instruction ROM and
  data RAM live here; each test loads a program under reset, runs it to
  its halt loop and checks the writes seen on the data port.
*/
`timescale 1ns/1ps

module tb_rv_core;

  localparam int reset_cycles  = 10;
  localparam int nop_cycles    = 8;
  localparam int arith_budget  = 64;
  localparam int copy_budget   = 24;
  localparam int branch_budget = 64;
  localparam int jump_budget   = 24;
  localparam int total_cycles  = 5 * (reset_cycles + 2) + nop_cycles + arith_budget
                                 + copy_budget + branch_budget + jump_budget;
  localparam rv_pkg::word_t nop = 32'h0000_0013;
  localparam logic [11:0] reset_store_addr = 12'h3fc;

  logic              clock;
  logic              rst_n;
  rv_pkg::addr_t     inst_addr;
  rv_pkg::word_t     inst;
  rv_pkg::dmem_req_t dmem_req;
  rv_pkg::word_t     data_rdata;

  rv_pkg::word_t rom [256];
  rv_pkg::word_t ram [256];
  int            prog_len;
  rv_pkg::addr_t halt_pc;
  integer        seed;

  rv_pkg::addr_t store_addr_q [$];
  rv_pkg::word_t store_data_q [$];
  rv_pkg::addr_t exp_addr_q [$];
  rv_pkg::word_t exp_data_q [$];
  rv_pkg::addr_t pc_trace [$];

  `include "tb_rv_programs.svh"

  rv_core i_rv_core (
    .clock      (clock),
    .rst_n      (rst_n),
    .inst_addr  (inst_addr),
    .inst       (inst),
    .dmem_req   (dmem_req),
    .data_rdata (data_rdata)
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;

  // Word-addressed memories, combinational reads
  assign inst       = rom[inst_addr[9:2]];
  assign data_rdata = ram[dmem_req.addr[9:2]];

  always @(posedge clock) begin
    if (rst_n && dmem_req.write_enable) begin
      ram[dmem_req.addr[9:2]] <= dmem_req.wdata;
      store_addr_q.push_back(dmem_req.addr);
      store_data_q.push_back(dmem_req.wdata);
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t expected,
                            input rv_pkg::word_t actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("** Error at %0t: %s expected %h, actual %h",
                                $time, name, expected, actual));
    end
  endtask

  task automatic check_addr(input string name, input rv_pkg::addr_t expected,
                            input rv_pkg::addr_t actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("** Error at %0t: %s expected %h, actual %h",
                                $time, name, expected, actual));
    end
  endtask

  task automatic expect_store(input rv_pkg::addr_t addr, input rv_pkg::word_t data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  task automatic compare_stores();
    if (store_addr_q.size() != exp_addr_q.size()) begin
      stop_on_failure($sformatf("Saw %0d data writes where %0d were expected",
                                store_addr_q.size(), exp_addr_q.size()));
    end else begin
      foreach (exp_addr_q[i]) begin
        check_addr("dmem_req.addr", exp_addr_q[i], store_addr_q[i]);
        check_word("dmem_req.wdata", exp_data_q[i], store_data_q[i]);
      end
    end
  endtask

  // Finds the fetch that follows the jump at from
  task automatic check_jump(input rv_pkg::addr_t from, input rv_pkg::addr_t to);
    int hit;
    hit = -1;
    for (int i = 0; i + 1 < pc_trace.size(); i++) begin
      if (hit < 0 && pc_trace[i] == from) begin
        hit = i;
      end
    end
    if (hit < 0) begin
      stop_on_failure($sformatf("Jump at %h was never fetched", from));
    end else begin
      check_addr("inst_addr", to, pc_trace[hit + 1]);
    end
  endtask

  // ------------------------------
  // Reference rules
  // ------------------------------
  function automatic rv_pkg::word_t expected_alu(input logic [3:0] op,
                                                 input rv_pkg::word_t a, b);
    rv_pkg::word_t r;
    case (op[2:0])
      3'd0: r = op[3] ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: r = op[3] ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_outcome(input logic [2:0] f3, input rv_pkg::word_t a, b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic rv_pkg::word_t ram_pattern(input logic [7:0] index);
    return (32'(index) + 32'd1) * 32'h9e37_79b9;
  endfunction

  task automatic fill_ram();
    for (int i = 0; i < 256; i++) begin
      ram[8'(i)] <= ram_pattern(8'(i));
    end
  endtask

  // ------------------------------
  // Reset and run control
  // ------------------------------
  task automatic enter_reset();
    @(posedge clock);
    rst_n <= 1'b0;
    @(negedge clock);
    store_addr_q.delete();
    store_data_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  task automatic leave_reset();
    repeat (reset_cycles - 1) begin
      @(negedge clock);
      if (dmem_req.write_enable !== 1'b0) begin
        stop_on_failure("Data write enable went high while reset was held");
      end
    end
    @(posedge clock);
    rst_n <= 1'b1;
  endtask

  task automatic run_to_halt(input int budget);
    int cycles;
    cycles = 0;
    pc_trace.delete();
    do begin
      @(negedge clock);
      pc_trace.push_back(inst_addr);
      cycles++;
      if (cycles > budget) begin
        stop_on_failure("Program did not reach its halt loop in time");
      end
    end while (inst_addr != halt_pc);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic reset_and_count();
    rv_pkg::addr_t expected_pc;
    enter_reset();
    clear_rom();
    // A store at the reset PC stays idle until reset is released
    put(s_type(5'd0, 5'd0, reset_store_addr));
    fill_ram();
    leave_reset();
    expect_store(32'(reset_store_addr), 32'd0);
    expected_pc = rv_pkg::INITIAL_PC;
    repeat (nop_cycles) begin
      @(negedge clock);
      check_addr("inst_addr", expected_pc, inst_addr);
      expected_pc = expected_pc + 32'd4;
    end
    compare_stores();
  endtask

  task automatic alu_ops();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t rnd;
    logic [11:0]   imm;
    logic [11:0]   field;
    logic [4:0]    shamt;
    // a negative and b positive so slt and sltu disagree
    a = $random(seed) | 32'h8000_0000;
    b = $random(seed) & 32'h7fff_ffff;
    rnd = $random(seed);
    imm = rnd[11:0];
    shamt = rnd[16:12];
    enter_reset();
    arith_program(a, b, imm, shamt);
    fill_ram();
    leave_reset();
    for (int k = 0; k < 10; k++) begin
      expect_store(32'(arith_base) + 32'(4 * k), expected_alu(r_ops[k], a, b));
    end
    for (int k = 0; k < 9; k++) begin
      field = imm_field(i_ops[k], imm, shamt);
      expect_store(32'(arith_base) + 32'(4 * (10 + k)),
                   expected_alu(i_ops[k], a, {{20{field[11]}}, field}));
    end
    expect_store(32'(arith_base) + 32'(4 * 19), 32'd0);
    run_to_halt(arith_budget);
    compare_stores();
  endtask

  task automatic load_store_copy();
    logic [11:0] imm;
    enter_reset();
    copy_program();
    fill_ram();
    leave_reset();
    for (int k = 0; k < 4; k++) begin
      imm = ls_imm[k];
      expect_store(32'(copy_base) + 32'(4 * k),
                   ram_pattern(8'(k)) + {{20{imm[11]}}, imm});
    end
    run_to_halt(copy_budget);
    compare_stores();
  endtask

  task automatic branch_paths();
    logic taken;
    enter_reset();
    branch_program();
    fill_ram();
    leave_reset();
    for (int c = 0; c < 12; c++) begin
      taken = branch_outcome(br_f3[c], branch_operand(br_rs1[c]), branch_operand(br_rs2[c]));
      expect_store(32'(marker_base) + 32'(4 * c),
                   taken ? 32'(taken_marker) + 32'(c) : 32'(fall_marker) + 32'(c));
    end
    run_to_halt(branch_budget);
    compare_stores();
  endtask

  task automatic jumps_and_upper();
    enter_reset();
    jump_program();
    fill_ram();
    leave_reset();
    expect_store(32'(jump_base), {lui_imm, 12'h000});
    expect_store(32'(jump_base) + 32'd4, 32'(auipc_pc) + {auipc_imm, 12'h000});
    expect_store(32'(jump_base) + 32'd8, 32'(jal_pc) + 32'd4);
    expect_store(32'(jump_base) + 32'd12, 32'(jalr_pc) + 32'd4);
    run_to_halt(jump_budget);
    compare_stores();
    check_jump(32'(jal_pc), 32'(jal_pc + jal_offset));
    check_jump(32'(jalr_pc), 32'(jalr_base + jalr_imm) & ~32'd1);
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    seed = 32'h3e3c;
    rst_n = 1'b0;
    clear_rom();
    fill_ram();
    reset_and_count();
    alu_ops();
    load_store_copy();
    branch_paths();
    jumps_and_upper();
    $display("** PASS **");
    $finish;
  end

  initial begin
    #(total_cycles * 4 * 2);
    $display("Watchdog expired before all tests finished");
    $display("** FAIL **");
    $fatal(1, "run stopped");
  end

endmodule

// ==== compile.f ====
+incdir+verif
src/rv_pkg.sv
src/alu.sv
src/immediate_generator.sv
src/regfile.sv
src/control_unit.sv
src/singlecycle_datapath.sv
src/rv_core.sv
verif/tb_rv_core.sv

// ==== Makefile ====
# Verilator build and run for the RV32I core testbench

TOP := tb_rv_core

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	grep -q -x -F '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
